//--- cache_pkg.sv
package cache_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    // direct-mapped, one word per line
    localparam int cache_sets = 32;
    localparam int index_w = 5;
    localparam int tag_w = 25;
    localparam int offset_w = 2;

    localparam int cbus_masters = 4;

    // top three address bits of the fixed segments
    localparam logic [2:0] kseg0_top = 3'b100;
    localparam logic [2:0] kseg1_top = 3'b101;

    // controller states shared by the caches and the bridge
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_bus = 2'd1;
    localparam logic [1:0] st_resp = 2'd2;

    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0] tag;
            logic [index_w-1:0] index;
            logic [offset_w-1:0] offset;
        } f;
    } phys_addr_t;

endpackage

//--- icache.sv
`timescale 1ns/1ps

module icache (
    input  logic clk,
    input  logic reset,
    input  logic ireq_valid,
    input  cache_pkg::phys_addr_t ireq_addr,
    output logic iresp_addr_ok,
    output logic iresp_data_ok,
    output logic [cache_pkg::data_w-1:0] iresp_data,
    output logic creq_valid,
    output logic creq_write,
    output logic [cache_pkg::addr_w-1:0] creq_addr,
    output logic [cache_pkg::strb_w-1:0] creq_strobe,
    output logic [cache_pkg::data_w-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic [cache_pkg::data_w-1:0] cresp_data
);

    logic [1:0] state;
    logic [cache_pkg::cache_sets-1:0] valid_q;
    logic [cache_pkg::tag_w-1:0] tag_q [cache_pkg::cache_sets];
    logic [cache_pkg::data_w-1:0] data_q [cache_pkg::cache_sets];
    cache_pkg::phys_addr_t addr_q;
    logic hit;

    // lookup on the incoming request, before it is latched
    assign hit = valid_q[ireq_addr.f.index] && tag_q[ireq_addr.f.index] == ireq_addr.f.tag;

    assign iresp_addr_ok = ireq_valid && state == cache_pkg::st_idle;
    assign iresp_data_ok = state == cache_pkg::st_resp;
    assign iresp_data = data_q[addr_q.f.index];

    // read-only, so only word reads reach the bus
    assign creq_valid = state == cache_pkg::st_bus;
    assign creq_write = 1'b0;
    assign creq_addr = addr_q.raw;
    assign creq_strobe = '0;
    assign creq_wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::st_idle;
            valid_q <= '0;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (iresp_addr_ok) begin
                        state <= hit ? cache_pkg::st_resp : cache_pkg::st_bus;
                    end
                end
                cache_pkg::st_bus: begin
                    if (cresp_ready) begin
                        valid_q[addr_q.f.index] <= 1'b1;
                        state <= cache_pkg::st_resp;
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (iresp_addr_ok) begin
            addr_q <= ireq_addr;
        end
        // line fill
        if (creq_valid && cresp_ready) begin
            tag_q[addr_q.f.index] <= addr_q.f.tag;
            data_q[addr_q.f.index] <= cresp_data;
        end
    end

endmodule

//--- dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic clk,
    input  logic reset,
    input  logic dreq_1_valid,
    input  cache_pkg::phys_addr_t dreq_1_addr,
    input  logic dreq_1_write,
    input  logic [cache_pkg::strb_w-1:0] dreq_1_strobe,
    input  logic [cache_pkg::data_w-1:0] dreq_1_wdata,
    output logic dresp_1_addr_ok,
    output logic dresp_1_data_ok,
    output logic [cache_pkg::data_w-1:0] dresp_1_data,
    input  logic dreq_2_valid,
    input  cache_pkg::phys_addr_t dreq_2_addr,
    input  logic dreq_2_write,
    input  logic [cache_pkg::strb_w-1:0] dreq_2_strobe,
    input  logic [cache_pkg::data_w-1:0] dreq_2_wdata,
    output logic dresp_2_addr_ok,
    output logic dresp_2_data_ok,
    output logic [cache_pkg::data_w-1:0] dresp_2_data,
    output logic creq_valid,
    output logic creq_write,
    output logic [cache_pkg::addr_w-1:0] creq_addr,
    output logic [cache_pkg::strb_w-1:0] creq_strobe,
    output logic [cache_pkg::data_w-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic [cache_pkg::data_w-1:0] cresp_data
);

    logic [1:0] state;
    logic [cache_pkg::cache_sets-1:0] valid_q;
    logic [cache_pkg::tag_w-1:0] tag_q [cache_pkg::cache_sets];
    logic [cache_pkg::data_w-1:0] data_q [cache_pkg::cache_sets];

    // one request slot per port
    cache_pkg::phys_addr_t r1_addr;
    cache_pkg::phys_addr_t r2_addr;
    logic r1_write;
    logic r2_write;
    logic [cache_pkg::strb_w-1:0] r1_strobe;
    logic [cache_pkg::strb_w-1:0] r2_strobe;
    logic [cache_pkg::data_w-1:0] r1_wdata;
    logic [cache_pkg::data_w-1:0] r2_wdata;

    logic pend_2;
    logic cur_2;
    logic done;

    cache_pkg::phys_addr_t cur_addr;
    logic cur_write;
    logic [cache_pkg::strb_w-1:0] cur_strobe;
    logic [cache_pkg::data_w-1:0] cur_wdata;
    logic [cache_pkg::data_w-1:0] merged;
    logic hit;
    logic finish;

    always_comb begin
        cur_addr = cur_2 ? r2_addr : r1_addr;
        cur_write = cur_2 ? r2_write : r1_write;
        cur_strobe = cur_2 ? r2_strobe : r1_strobe;
        cur_wdata = cur_2 ? r2_wdata : r1_wdata;
    end

    always_comb begin
        merged = data_q[cur_addr.f.index];
        for (int i = 0; i < cache_pkg::strb_w; i++) begin
            if (cur_strobe[i]) begin
                merged[8*i +: 8] = cur_wdata[8*i +: 8];
            end
        end
    end

    assign hit = valid_q[cur_addr.f.index] && tag_q[cur_addr.f.index] == cur_addr.f.tag;
    // reads finish on a hit, stores once their write-through is done
    assign finish = state == cache_pkg::st_resp && (done || (!cur_write && hit));

    assign dresp_1_addr_ok = dreq_1_valid && state == cache_pkg::st_idle;
    assign dresp_2_addr_ok = dreq_2_valid && state == cache_pkg::st_idle;
    assign dresp_1_data_ok = finish && !cur_2;
    assign dresp_2_data_ok = finish && cur_2;
    assign dresp_1_data = data_q[cur_addr.f.index];
    assign dresp_2_data = data_q[cur_addr.f.index];

    assign creq_valid = state == cache_pkg::st_bus;
    assign creq_write = cur_write;
    assign creq_addr = cur_addr.raw;
    assign creq_strobe = cur_write ? cur_strobe : '0;
    assign creq_wdata = cur_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::st_idle;
            valid_q <= '0;
            pend_2 <= 1'b0;
            cur_2 <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (dresp_1_addr_ok || dresp_2_addr_ok) begin
                        pend_2 <= dresp_2_addr_ok;
                        cur_2 <= !dresp_1_addr_ok;
                        state <= cache_pkg::st_resp;
                    end
                end
                cache_pkg::st_resp: begin
                    if (finish) begin
                        done <= 1'b0;
                        // port 2 waits behind port 1
                        if (!cur_2 && pend_2) begin
                            cur_2 <= 1'b1;
                        end else begin
                            pend_2 <= 1'b0;
                            state <= cache_pkg::st_idle;
                        end
                    end else begin
                        state <= cache_pkg::st_bus;
                    end
                end
                cache_pkg::st_bus: begin
                    if (cresp_ready) begin
                        done <= 1'b1;
                        state <= cache_pkg::st_resp;
                        if (!cur_write) begin
                            valid_q[cur_addr.f.index] <= 1'b1;
                        end
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dresp_1_addr_ok) begin
            r1_addr <= dreq_1_addr;
            r1_write <= dreq_1_write;
            r1_strobe <= dreq_1_strobe;
            r1_wdata <= dreq_1_wdata;
        end
        if (dresp_2_addr_ok) begin
            r2_addr <= dreq_2_addr;
            r2_write <= dreq_2_write;
            r2_strobe <= dreq_2_strobe;
            r2_wdata <= dreq_2_wdata;
        end
        // store hit updates the line, a store miss leaves it alone
        if (state == cache_pkg::st_resp && !finish && cur_write && hit) begin
            data_q[cur_addr.f.index] <= merged;
        end
        if (creq_valid && cresp_ready && !cur_write) begin
            tag_q[cur_addr.f.index] <= cur_addr.f.tag;
            data_q[cur_addr.f.index] <= cresp_data;
        end
    end

endmodule

//--- uncached_bridge.sv
`timescale 1ns/1ps

module uncached_bridge (
    input  logic clk,
    input  logic reset,
    input  logic dreq_valid,
    input  logic [cache_pkg::addr_w-1:0] dreq_addr,
    input  logic dreq_write,
    input  logic [cache_pkg::strb_w-1:0] dreq_strobe,
    input  logic [cache_pkg::data_w-1:0] dreq_wdata,
    output logic dresp_addr_ok,
    output logic dresp_data_ok,
    output logic [cache_pkg::data_w-1:0] dresp_data,
    output logic creq_valid,
    output logic creq_write,
    output logic [cache_pkg::addr_w-1:0] creq_addr,
    output logic [cache_pkg::strb_w-1:0] creq_strobe,
    output logic [cache_pkg::data_w-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic [cache_pkg::data_w-1:0] cresp_data
);

    logic [1:0] state;
    logic [cache_pkg::data_w-1:0] rdata_q;

    assign dresp_addr_ok = dreq_valid && state == cache_pkg::st_idle;
    assign dresp_data_ok = state == cache_pkg::st_resp;
    assign dresp_data = rdata_q;
    assign creq_valid = state == cache_pkg::st_bus;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::st_idle;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (dresp_addr_ok) begin
                        state <= cache_pkg::st_bus;
                    end
                end
                cache_pkg::st_bus: begin
                    if (cresp_ready) begin
                        state <= cache_pkg::st_resp;
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    // request held on the bus straight from these registers
    always_ff @(posedge clk) begin
        if (dresp_addr_ok) begin
            creq_write <= dreq_write;
            creq_addr <= dreq_addr;
            creq_strobe <= dreq_strobe;
            creq_wdata <= dreq_wdata;
        end
        if (creq_valid && cresp_ready) begin
            rdata_q <= cresp_data;
        end
    end

endmodule

//--- cbus_arbiter.sv
`timescale 1ns/1ps

module cbus_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic [cache_pkg::cbus_masters-1:0] m_valid,
    input  logic [cache_pkg::cbus_masters-1:0] m_write,
    input  logic [cache_pkg::cbus_masters-1:0][cache_pkg::addr_w-1:0] m_addr,
    input  logic [cache_pkg::cbus_masters-1:0][cache_pkg::data_w-1:0] m_wdata,
    input  logic [cache_pkg::cbus_masters-1:0][cache_pkg::strb_w-1:0] m_strobe,
    output logic [cache_pkg::cbus_masters-1:0] m_ready,
    output logic [cache_pkg::data_w-1:0] m_data,
    output logic creq_valid,
    output logic creq_write,
    output logic [cache_pkg::addr_w-1:0] creq_addr,
    output logic [cache_pkg::strb_w-1:0] creq_strobe,
    output logic [cache_pkg::data_w-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic [cache_pkg::data_w-1:0] cresp_data
);

    localparam int grant_w = $clog2(cache_pkg::cbus_masters);

    logic locked;
    logic [grant_w-1:0] grant_q;
    logic [grant_w-1:0] grant_pick;
    logic [grant_w-1:0] grant;

    // lowest index wins
    always_comb begin
        grant_pick = '0;
        for (int i = cache_pkg::cbus_masters - 1; i >= 0; i--) begin
            if (m_valid[i]) begin
                grant_pick = grant_w'(i);
            end
        end
    end

    assign grant = locked ? grant_q : grant_pick;

    assign creq_valid = m_valid[grant];
    assign creq_write = m_write[grant];
    assign creq_addr = m_addr[grant];
    assign creq_strobe = m_strobe[grant];
    assign creq_wdata = m_wdata[grant];

    always_comb begin
        m_ready = '0;
        m_ready[grant] = creq_valid && cresp_ready;
    end
    assign m_data = cresp_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked <= 1'b0;
            grant_q <= '0;
        end else if (creq_valid && !cresp_ready) begin
            locked <= 1'b1;
            grant_q <= grant;
        end else if (cresp_ready) begin
            locked <= 1'b0;
        end
    end

endmodule

//--- cache_manage.sv
`timescale 1ns/1ps

module cache_manage (
    input  logic clk,
    input  logic reset,
    input  logic ireq_valid,
    input  logic [cache_pkg::addr_w-1:0] ireq_addr,
    output logic iresp_addr_ok,
    output logic iresp_data_ok,
    output logic [cache_pkg::data_w-1:0] iresp_data,
    input  logic dreq_1_valid,
    input  logic [cache_pkg::addr_w-1:0] dreq_1_addr,
    input  logic dreq_1_write,
    input  logic [cache_pkg::strb_w-1:0] dreq_1_strobe,
    input  logic [cache_pkg::data_w-1:0] dreq_1_wdata,
    output logic dresp_1_addr_ok,
    output logic dresp_1_data_ok,
    output logic [cache_pkg::data_w-1:0] dresp_1_data,
    input  logic dreq_2_valid,
    input  logic [cache_pkg::addr_w-1:0] dreq_2_addr,
    input  logic dreq_2_write,
    input  logic [cache_pkg::strb_w-1:0] dreq_2_strobe,
    input  logic [cache_pkg::data_w-1:0] dreq_2_wdata,
    output logic dresp_2_addr_ok,
    output logic dresp_2_data_ok,
    output logic [cache_pkg::data_w-1:0] dresp_2_data,
    output logic creq_valid,
    output logic creq_write,
    output logic [cache_pkg::addr_w-1:0] creq_addr,
    output logic [cache_pkg::strb_w-1:0] creq_strobe,
    output logic [cache_pkg::data_w-1:0] creq_wdata,
    input  logic cresp_ready,
    input  logic [cache_pkg::data_w-1:0] cresp_data
);

    cache_pkg::phys_addr_t i_paddr;
    cache_pkg::phys_addr_t d1_paddr;
    cache_pkg::phys_addr_t d2_paddr;
    logic d1_uncached;
    logic d2_uncached;

    // outstanding request per port, and whether it went to the bridge
    logic busy_1;
    logic busy_2;
    logic route_1;
    logic route_2;

    logic dc1_valid;
    logic dc2_valid;
    logic dc1_addr_ok;
    logic dc2_addr_ok;
    logic dc1_data_ok;
    logic dc2_data_ok;
    logic [cache_pkg::data_w-1:0] dc1_data;
    logic [cache_pkg::data_w-1:0] dc2_data;
    logic br1_valid;
    logic br2_valid;
    logic br1_addr_ok;
    logic br2_addr_ok;
    logic br1_data_ok;
    logic br2_data_ok;
    logic [cache_pkg::data_w-1:0] br1_data;
    logic [cache_pkg::data_w-1:0] br2_data;

    // master 0 bridge 1, 1 dcache, 2 bridge 2, 3 icache
    logic [cache_pkg::cbus_masters-1:0] m_valid;
    logic [cache_pkg::cbus_masters-1:0] m_write;
    logic [cache_pkg::cbus_masters-1:0] m_ready;
    logic [cache_pkg::cbus_masters-1:0][cache_pkg::addr_w-1:0] m_addr;
    logic [cache_pkg::cbus_masters-1:0][cache_pkg::data_w-1:0] m_wdata;
    logic [cache_pkg::cbus_masters-1:0][cache_pkg::strb_w-1:0] m_strobe;
    logic [cache_pkg::data_w-1:0] m_data;

    // kseg0 and kseg1 drop their segment bits, the rest maps one to one
    function automatic logic [cache_pkg::addr_w-1:0] translate(
        input logic [cache_pkg::addr_w-1:0] vaddr
    );
        logic [2:0] seg;
        seg = vaddr[cache_pkg::addr_w-1 -: 3];
        if (seg == cache_pkg::kseg0_top || seg == cache_pkg::kseg1_top) begin
            return {3'b000, vaddr[cache_pkg::addr_w-4:0]};
        end
        return vaddr;
    endfunction

    always_comb begin
        i_paddr.raw = translate(ireq_addr);
        d1_paddr.raw = translate(dreq_1_addr);
        d2_paddr.raw = translate(dreq_2_addr);
    end

    assign d1_uncached = dreq_1_addr[cache_pkg::addr_w-1 -: 3] == cache_pkg::kseg1_top;
    assign d2_uncached = dreq_2_addr[cache_pkg::addr_w-1 -: 3] == cache_pkg::kseg1_top;

    assign dc1_valid = dreq_1_valid && !busy_1 && !d1_uncached;
    assign br1_valid = dreq_1_valid && !busy_1 && d1_uncached;
    assign dc2_valid = dreq_2_valid && !busy_2 && !d2_uncached;
    assign br2_valid = dreq_2_valid && !busy_2 && d2_uncached;

    assign dresp_1_addr_ok = d1_uncached ? br1_addr_ok : dc1_addr_ok;
    assign dresp_2_addr_ok = d2_uncached ? br2_addr_ok : dc2_addr_ok;
    assign dresp_1_data_ok = route_1 ? br1_data_ok : dc1_data_ok;
    assign dresp_2_data_ok = route_2 ? br2_data_ok : dc2_data_ok;
    assign dresp_1_data = route_1 ? br1_data : dc1_data;
    assign dresp_2_data = route_2 ? br2_data : dc2_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_1 <= 1'b0;
            busy_2 <= 1'b0;
            route_1 <= 1'b0;
            route_2 <= 1'b0;
        end else begin
            if (dresp_1_addr_ok) begin
                busy_1 <= 1'b1;
                route_1 <= d1_uncached;
            end else if (dresp_1_data_ok) begin
                busy_1 <= 1'b0;
            end
            if (dresp_2_addr_ok) begin
                busy_2 <= 1'b1;
                route_2 <= d2_uncached;
            end else if (dresp_2_data_ok) begin
                busy_2 <= 1'b0;
            end
        end
    end

    icache u_icache (
        .clk, .reset,
        .ireq_valid, .ireq_addr(i_paddr), .iresp_addr_ok, .iresp_data_ok, .iresp_data,
        .creq_valid(m_valid[3]), .creq_write(m_write[3]), .creq_addr(m_addr[3]),
        .creq_strobe(m_strobe[3]), .creq_wdata(m_wdata[3]),
        .cresp_ready(m_ready[3]), .cresp_data(m_data)
    );

    dcache u_dcache (
        .clk, .reset,
        .dreq_1_valid(dc1_valid), .dreq_1_addr(d1_paddr), .dreq_1_write,
        .dreq_1_strobe, .dreq_1_wdata, .dresp_1_addr_ok(dc1_addr_ok),
        .dresp_1_data_ok(dc1_data_ok), .dresp_1_data(dc1_data),
        .dreq_2_valid(dc2_valid), .dreq_2_addr(d2_paddr), .dreq_2_write,
        .dreq_2_strobe, .dreq_2_wdata, .dresp_2_addr_ok(dc2_addr_ok),
        .dresp_2_data_ok(dc2_data_ok), .dresp_2_data(dc2_data),
        .creq_valid(m_valid[1]), .creq_write(m_write[1]), .creq_addr(m_addr[1]),
        .creq_strobe(m_strobe[1]), .creq_wdata(m_wdata[1]),
        .cresp_ready(m_ready[1]), .cresp_data(m_data)
    );

    uncached_bridge u_bridge_1 (
        .clk, .reset,
        .dreq_valid(br1_valid), .dreq_addr(d1_paddr.raw), .dreq_write(dreq_1_write),
        .dreq_strobe(dreq_1_strobe), .dreq_wdata(dreq_1_wdata),
        .dresp_addr_ok(br1_addr_ok), .dresp_data_ok(br1_data_ok), .dresp_data(br1_data),
        .creq_valid(m_valid[0]), .creq_write(m_write[0]), .creq_addr(m_addr[0]),
        .creq_strobe(m_strobe[0]), .creq_wdata(m_wdata[0]),
        .cresp_ready(m_ready[0]), .cresp_data(m_data)
    );

    uncached_bridge u_bridge_2 (
        .clk, .reset,
        .dreq_valid(br2_valid), .dreq_addr(d2_paddr.raw), .dreq_write(dreq_2_write),
        .dreq_strobe(dreq_2_strobe), .dreq_wdata(dreq_2_wdata),
        .dresp_addr_ok(br2_addr_ok), .dresp_data_ok(br2_data_ok), .dresp_data(br2_data),
        .creq_valid(m_valid[2]), .creq_write(m_write[2]), .creq_addr(m_addr[2]),
        .creq_strobe(m_strobe[2]), .creq_wdata(m_wdata[2]),
        .cresp_ready(m_ready[2]), .cresp_data(m_data)
    );

    cbus_arbiter u_arbiter (
        .clk, .reset,
        .m_valid, .m_write, .m_addr, .m_wdata, .m_strobe, .m_ready, .m_data,
        .creq_valid, .creq_write, .creq_addr, .creq_strobe, .creq_wdata,
        .cresp_ready, .cresp_data
    );

endmodule

//--- cache_manage_sva.sv
`timescale 1ns/1ps

module cache_manage_sva (
    input logic clk,
    input logic reset,
    input logic ireq_valid,
    input logic iresp_addr_ok,
    input logic iresp_data_ok,
    input logic dreq_1_valid,
    input logic dresp_1_addr_ok,
    input logic dresp_1_data_ok,
    input logic dreq_2_valid,
    input logic dresp_2_addr_ok,
    input logic dresp_2_data_ok,
    input logic creq_valid,
    input logic creq_write,
    input logic [31:0] creq_addr,
    input logic [3:0] creq_strobe,
    input logic [31:0] creq_wdata,
    input logic cresp_ready
);

    int fail_count = 0;
    logic open_i;
    logic open_1;
    logic open_2;

    // one outstanding request per core port
    always_ff @(posedge clk) begin
        if (reset) begin
            open_i <= 1'b0;
            open_1 <= 1'b0;
            open_2 <= 1'b0;
        end else begin
            if (ireq_valid && iresp_addr_ok) begin
                open_i <= 1'b1;
            end else if (iresp_data_ok) begin
                open_i <= 1'b0;
            end
            if (dreq_1_valid && dresp_1_addr_ok) begin
                open_1 <= 1'b1;
            end else if (dresp_1_data_ok) begin
                open_1 <= 1'b0;
            end
            if (dreq_2_valid && dresp_2_addr_ok) begin
                open_2 <= 1'b1;
            end else if (dresp_2_data_ok) begin
                open_2 <= 1'b0;
            end
        end
    end

    addr_ok_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (!iresp_addr_ok || (ireq_valid && !open_i))
            && (!dresp_1_addr_ok || (dreq_1_valid && !open_1))
            && (!dresp_2_addr_ok || (dreq_2_valid && !open_2)))
    else begin
        $error("addr_ok raised without valid or with a request still outstanding");
        fail_count++;
    end

    bus_request_held: assert property (@(posedge clk) disable iff (reset)
        creq_valid && !cresp_ready |=> creq_valid && $stable(creq_write)
            && $stable(creq_addr) && $stable(creq_strobe) && $stable(creq_wdata))
    else begin
        $error("memory bus request changed before cresp_ready");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |->
        !creq_valid && !iresp_addr_ok && !iresp_data_ok && !dresp_1_addr_ok
            && !dresp_1_data_ok && !dresp_2_addr_ok && !dresp_2_data_ok)
    else begin
        $error("handshake output high in the first cycle after reset");
        fail_count++;
    end

    data_ok_needs_request: assert property (@(posedge clk) disable iff (reset)
        (!iresp_data_ok || open_i) && (!dresp_1_data_ok || open_1)
            && (!dresp_2_data_ok || open_2))
    else begin
        $error("data_ok without an outstanding request");
        fail_count++;
    end

endmodule

bind cache_manage cache_manage_sva u_sva (.*);

//--- tb_cache_manage.sv
`timescale 1ns/1ps

module tb_cache_manage;

    // worst case is near 2000 cycles of directed and random traffic
    localparam int max_cycles = 4000;
    localparam int mem_words = 4096;
    localparam int random_pairs = 50;
    localparam int random_fetches = 40;

    logic clk;
    logic reset;
    logic ireq_valid;
    logic [31:0] ireq_addr;
    wire iresp_addr_ok;
    wire iresp_data_ok;
    wire [31:0] iresp_data;
    logic d_valid [1:2];
    logic [31:0] d_addr [1:2];
    logic d_write [1:2];
    logic [3:0] d_strobe [1:2];
    logic [31:0] d_wdata [1:2];
    wire d_addr_ok [1:2];
    wire d_data_ok [1:2];
    wire [31:0] d_data [1:2];
    wire creq_valid;
    wire creq_write;
    wire [31:0] creq_addr;
    wire [3:0] creq_strobe;
    wire [31:0] creq_wdata;
    logic cresp_ready;
    logic [31:0] cresp_data;

    logic [31:0] mem [mem_words];
    logic [31:0] shadow [mem_words];
    int bus_wait;
    int cycles;
    int errors;
    int done_cycle [1:2];

    cache_manage UUT (
        .clk, .reset,
        .ireq_valid, .ireq_addr, .iresp_addr_ok, .iresp_data_ok, .iresp_data,
        .dreq_1_valid(d_valid[1]), .dreq_1_addr(d_addr[1]), .dreq_1_write(d_write[1]),
        .dreq_1_strobe(d_strobe[1]), .dreq_1_wdata(d_wdata[1]),
        .dresp_1_addr_ok(d_addr_ok[1]), .dresp_1_data_ok(d_data_ok[1]),
        .dresp_1_data(d_data[1]),
        .dreq_2_valid(d_valid[2]), .dreq_2_addr(d_addr[2]), .dreq_2_write(d_write[2]),
        .dreq_2_strobe(d_strobe[2]), .dreq_2_wdata(d_wdata[2]),
        .dresp_2_addr_ok(d_addr_ok[2]), .dresp_2_data_ok(d_data_ok[2]),
        .dresp_2_data(d_data[2]),
        .creq_valid, .creq_write, .creq_addr, .creq_strobe, .creq_wdata,
        .cresp_ready, .cresp_data
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old,
        input logic [31:0] wdata,
        input logic [3:0] strobe
    );
        logic [31:0] result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                result[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return result;
    endfunction

    // memory answers 1 to 3 cycles after it sees a request
    always @(posedge clk) begin
        cresp_ready <= 1'b0;
        if (!reset && creq_valid && !cresp_ready) begin
            if (bus_wait == 0) begin
                bus_wait <= $urandom % 3 + 1;
            end else if (bus_wait == 1) begin
                bus_wait <= 0;
                cresp_ready <= 1'b1;
                cresp_data <= mem[creq_addr[13:2]];
                if (creq_write) begin
                    mem[creq_addr[13:2]] <= merge_bytes(mem[creq_addr[13:2]], creq_wdata,
                        creq_strobe);
                end
            end else begin
                bus_wait <= bus_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: traffic still running after %0d cycles", max_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input string name);
        logic [31:0] expected;
        expected = shadow[addr[13:2]];
        ireq_valid <= 1'b1;
        ireq_addr <= addr;
        @(posedge clk);
        while (!iresp_addr_ok) begin
            @(posedge clk);
        end
        ireq_valid <= 1'b0;
        @(posedge clk);
        while (!iresp_data_ok) begin
            @(posedge clk);
        end
        check_value(name, expected, iresp_data);
    endtask

    task automatic data_access(input int p, input logic [31:0] addr, input logic write,
        input logic [3:0] strobe, input logic [31:0] wdata, input string name);
        logic [31:0] expected;
        if (write) begin
            shadow[addr[13:2]] = merge_bytes(shadow[addr[13:2]], wdata, strobe);
        end
        expected = shadow[addr[13:2]];
        d_valid[p] <= 1'b1;
        d_addr[p] <= addr;
        d_write[p] <= write;
        d_strobe[p] <= strobe;
        d_wdata[p] <= wdata;
        @(posedge clk);
        while (!d_addr_ok[p]) begin
            @(posedge clk);
        end
        d_valid[p] <= 1'b0;
        @(posedge clk);
        while (!d_data_ok[p]) begin
            @(posedge clk);
        end
        done_cycle[p] = cycles;
        if (!write) begin
            check_value(name, expected, d_data[p]);
        end
    endtask

    // port 2 words live above 0x1000 so the two ports never share a word
    task automatic random_access(input int p);
        logic [31:0] phys;
        logic [31:0] seg;
        int kind;
        kind = $urandom % 4;
        phys = (p == 2 ? 32'h1000 : 32'h0) + ($urandom % 96) * 4;
        seg = ($urandom % 2) ? 32'h8000_0000 : 32'h0000_0000;
        case (kind)
            0, 1: data_access(p, seg | phys, 1'b0, 4'h0, 32'h0, "random_load");
            2: data_access(p, seg | phys, 1'b1, $urandom % 15 + 1, $urandom, "random_store");
            default: data_access(p, 32'ha000_0000 | phys, 1'b0, 4'h0, 32'h0, "random_uncached");
        endcase
    endtask

    initial begin
        logic [31:0] seg_1;
        logic [31:0] seg_2;
        void'($urandom(32'hcfaf_a86e));
        clk = 1'b0;
        reset = 1'b1;
        ireq_valid = 1'b0;
        ireq_addr = '0;
        cresp_ready = 1'b0;
        cresp_data = '0;
        bus_wait = 0;
        cycles = 0;
        errors = 0;
        for (int p = 1; p <= 2; p++) begin
            d_valid[p] = 1'b0;
            d_addr[p] = '0;
            d_write[p] = 1'b0;
            d_strobe[p] = '0;
            d_wdata[p] = '0;
            done_cycle[p] = 0;
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000;
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // fetch, hit, conflict, refetch
        fetch(32'h8000_2000, "fetch_first");
        fetch(32'h8000_2000, "fetch_repeat");
        fetch(32'h8000_2080, "fetch_conflict");
        fetch(32'h8000_2000, "fetch_after_evict");

        // 0x10 and 0x90 share index 4
        data_access(1, 32'h8000_0010, 1'b0, 4'h0, 32'h0, "load_kseg0");
        data_access(1, 32'h0000_0090, 1'b0, 4'h0, 32'h0, "load_unmapped");
        data_access(1, 32'h8000_0010, 1'b0, 4'h0, 32'h0, "load_evicted");
        data_access(2, 32'h8000_1010, 1'b0, 4'h0, 32'h0, "load_port2");
        data_access(2, 32'h0000_1010, 1'b0, 4'h0, 32'h0, "load_port2_hit");

        data_access(1, 32'h8000_0200, 1'b0, 4'h0, 32'h0, "load_before_store");
        data_access(1, 32'h8000_0200, 1'b1, 4'b0101, 32'hdead_beef, "store_hit");
        data_access(1, 32'h8000_0200, 1'b0, 4'h0, 32'h0, "load_after_store");
        data_access(2, 32'ha000_0200, 1'b0, 4'h0, 32'h0, "uncached_after_store");
        data_access(2, 32'h8000_1300, 1'b1, 4'b1000, 32'h1234_5678, "store_miss");
        data_access(2, 32'ha000_1300, 1'b0, 4'h0, 32'h0, "uncached_after_miss");
        data_access(2, 32'h8000_1300, 1'b0, 4'h0, 32'h0, "load_after_miss");

        data_access(2, 32'ha000_1f00, 1'b1, 4'b1111, 32'hcafe_f00d, "uncached_store");
        data_access(1, 32'h8000_1f00, 1'b0, 4'h0, 32'h0, "load_after_uncached");

        // every cached and uncached mix in the same cycle
        for (int mix = 0; mix < 4; mix++) begin
            seg_1 = mix[0] ? 32'ha000_0000 : 32'h8000_0000;
            seg_2 = mix[1] ? 32'ha000_0000 : 32'h8000_0000;
            fork
                data_access(1, seg_1 | (32'h0400 + mix * 4), 1'b0, 4'h0, 32'h0, "mix_p1");
                data_access(2, seg_2 | (32'h1400 + mix * 4), 1'b0, 4'h0, 32'h0, "mix_p2");
            join
            if (mix == 0) begin
                assert (done_cycle[2] >= done_cycle[1]) else begin
                    $display("port 2 data_ok came before port 1 on a cached pair");
                    errors++;
                end
            end
        end
        fork
            data_access(1, 32'h8000_0404, 1'b1, 4'b0011, 32'h0bad_f00d, "pair_store");
            data_access(2, 32'h8000_1404, 1'b0, 4'h0, 32'h0, "pair_load");
        join
        assert (done_cycle[2] >= done_cycle[1]) else begin
            $display("port 2 data_ok came before port 1 behind a store");
            errors++;
        end

        fork
            begin
                for (int n = 0; n < random_fetches; n++) begin
                    fetch(32'h8000_2000 + ($urandom % 2048) * 4, "random_fetch");
                end
            end
            begin
                for (int n = 0; n < random_pairs; n++) begin
                    fork
                        random_access(1);
                        random_access(2);
                    join
                end
            end
        join

        repeat (4) @(posedge clk);
        $display("check errors: %0d, assertion errors: %0d", errors, UUT.u_sva.fail_count);
        if (errors == 0 && UUT.u_sva.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
cache_pkg.sv
icache.sv
dcache.sv
uncached_bridge.sv
cbus_arbiter.sv
cache_manage.sv
cache_manage_sva.sv
tb_cache_manage.sv
